// ==== led_panel_top.f ====
+incdir+design
design/led_panel_pkg.sv
design/column_if.sv
design/axil_pixel_writer.sv
design/pixel_ram.sv
design/column_buffer.sv
design/driver_shifter.sv
design/led_panel_top.sv
test/tb_led_panel.sv

// ==== Makefile ====
# Verilator simulation of the LED panel subsystem

VERILATOR  ?= verilator
TOP        ?= tb_led_panel
RTL_TOP    ?= led_panel_top
FLIST      ?= led_panel_top.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT  ?= PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)

# The log decides the result, the simulator exit code is not trusted
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_led_panel.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_panel_defines.svh"

module tb_led_panel;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    // Cycles that one handshake, or a number of status polls, may take
    localparam int AXI_LIMIT  = 20;
    // Cycles allowed for a run of column latches
    localparam int SCAN_LIMIT = 3000;

    logic                            clk;
    logic                            nrst;
    logic [`LED_AXI_ADDR_W-1:0]      awaddr;
    logic                            awvalid;
    logic                            awready;
    logic [`LED_AXI_DATA_W-1:0]      wdata;
    logic [`LED_AXI_DATA_W/8-1:0]    wstrb;
    logic                            wvalid;
    logic                            wready;
    logic [1:0]                      bresp;
    logic                            bvalid;
    logic                            bready;
    logic [`LED_AXI_ADDR_W-1:0]      araddr;
    logic                            arvalid;
    logic                            arready;
    logic [`LED_AXI_DATA_W-1:0]      rdata;
    logic [1:0]                      rresp;
    logic                            rvalid;
    logic                            rready;
    logic [`LED_DRIVERS-1:0]         sdo;
    logic                            shift_en;
    logic                            latch;
    logic [$clog2(`LED_COLUMNS)-1:0] col_sel;
    logic                            frame_done;

    logic [31:0] rng_state;
    // Expected pixel memory contents
    logic [`LED_CHANNELS-1:0] model [`LED_RAM_DEPTH];
    // Words rebuilt from the serial lanes, one per driver
    logic [`LED_CHANNELS-1:0] lane_words [`LED_DRIVERS];
    // Column that the next latch should show
    logic [2:0]  expect_col;
    int          bit_count;
    int          latch_count;
    int          frame_pulses;
    int          errors;
    int          tests_run;
    int          tests_failed;

    // Handshakes seen at the last rising edge
    logic        w_fire;
    logic        b_fire;
    logic        ar_fire;
    logic        r_fire;
    logic [1:0]  b_resp_seen;
    logic [1:0]  r_resp_seen;
    logic [31:0] r_data_seen;

    led_panel_top i_dut (
        .clk, .nrst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .sdo, .shift_en, .latch, .col_sel, .frame_done
    );

    always #20 clk = ~clk;

    always @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            w_fire  <= 1'b0;
            b_fire  <= 1'b0;
            ar_fire <= 1'b0;
            r_fire  <= 1'b0;
        end else begin
            w_fire  <= awvalid && awready && wvalid && wready;
            b_fire  <= bvalid && bready;
            ar_fire <= arvalid && arready;
            r_fire  <= rvalid && rready;
        end
    end

    // Response payloads are captured on the transfer edge itself
    always @(posedge clk) begin
        if (bvalid && bready) b_resp_seen <= bresp;
        if (rvalid && rready) begin
            r_data_seen <= rdata;
            r_resp_seen <= rresp;
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_run();
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        errors++;
        tests_failed++;
        finish_run();
    endtask

    task automatic end_test(input string name, input int errors_before);
        tests_run++;
        if (errors > errors_before) begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - errors_before);
        end else begin
            $display("Test %s passed", name);
        end
    endtask

    // Address and data go out together, then the response is taken
    task automatic axi_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > AXI_LIMIT) abort_on_timeout("write address and data");
        end while (!w_fire);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > AXI_LIMIT) abort_on_timeout("write response");
        end while (!b_fire);
        bready = 1'b0;
        resp   = b_resp_seen;
    endtask

    task automatic axi_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > AXI_LIMIT) abort_on_timeout("read address");
        end while (!ar_fire);
        arvalid = 1'b0;
        rready  = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > AXI_LIMIT) abort_on_timeout("read data");
        end while (!r_fire);
        rready = 1'b0;
        data   = r_data_seen;
        resp   = r_resp_seen;
    endtask

    // Only strobed colour bytes replace the stored ones
    task automatic write_pixel(input int idx, input logic [31:0] data, input logic [3:0] strb);
        logic [1:0] resp;
        axi_write(12'(idx * 4), data, strb, resp);
        check("pixel write response", 32'(RESP_OKAY), 32'(resp));
        for (int b = 0; b < 3; b++) begin
            if (strb[b]) model[idx][b*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    task automatic set_scan(input logic enable);
        logic [1:0] resp;
        axi_write(12'(`LED_REG_CTRL), {31'd0, enable}, 4'h1, resp);
        check("control write response", 32'(RESP_OKAY), 32'(resp));
    endtask

    task automatic wait_latches(input int target);
        int n;
        n = 0;
        while (latch_count < target) begin
            @(negedge clk);
            n++;
            if (n > SCAN_LIMIT) abort_on_timeout("column latches");
        end
    endtask

    // Busy drops once the buffer is idle while the shifter may still finish one column
    task automatic drain_scan();
        logic [31:0] status;
        logic [1:0]  resp;
        int          n;
        n = 0;
        do begin
            axi_read(12'(`LED_REG_STATUS), status, resp);
            n++;
            if (n > AXI_LIMIT) abort_on_timeout("status busy to clear");
        end while (status[8]);
        n = 0;
        while (shift_en || latch) begin
            @(negedge clk);
            n++;
            if (n > SCAN_LIMIT) abort_on_timeout("shifter to go idle");
        end
    endtask

    // The lane deserializer takes one bit per driver on each shift cycle, MSB first
    always @(negedge clk) begin
        if (shift_en) begin
            for (int d = 0; d < `LED_DRIVERS; d++) begin
                lane_words[d] = {lane_words[d][`LED_CHANNELS-2:0], sdo[d]};
            end
            bit_count++;
        end
        if (!latch) check("frame_done outside latch", 32'd0, 32'(frame_done));
        if (latch) begin
            latch_count++;
            check("shift cycles", 32'(`LED_CHANNELS), 32'(bit_count));
            check("column order", 32'(expect_col), 32'(col_sel));
            // Driver d of column c was written at pixel index c + 8 * d
            for (int d = 0; d < `LED_DRIVERS; d++) begin
                check("column data", 32'(model[int'(expect_col) + `LED_COLUMNS * d]),
                      32'(lane_words[d]));
            end
            check("frame pulse", 32'(expect_col == 3'd7), 32'(frame_done));
            if (frame_done) frame_pulses++;
            // Columns follow in order and wrap after the last one
            expect_col = expect_col + 3'd1;
            bit_count  = 0;
        end
    end

    initial begin
        logic [31:0] data;
        logic [31:0] status_before;
        logic [1:0]  resp;
        logic [11:0] bad_addr;
        int          errors_before;

        rng_state = 32'h1acb_aaec;
        clk = 1'b0;
        nrst = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        for (int d = 0; d < `LED_DRIVERS; d++) lane_words[d] = '0;
        expect_col = '0;
        bit_count = 0;
        latch_count = 0;
        frame_pulses = 0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (5) @(negedge clk);
        nrst = 1'b1;

        // Full words first since the memory starts undefined, then partial strobes
        errors_before = errors;
        for (int idx = 0; idx < `LED_RAM_DEPTH; idx++) write_pixel(idx, next_rand(), 4'hf);
        for (int idx = 0; idx < `LED_RAM_DEPTH; idx++) begin
            data = next_rand();
            write_pixel(idx, data, 4'(next_rand()));
        end
        for (int idx = 0; idx < `LED_RAM_DEPTH; idx++) begin
            axi_read(12'(idx * 4), data, resp);
            check("pixel readback", {8'h00, model[idx]}, data);
            check("pixel read response", 32'(RESP_OKAY), 32'(resp));
        end
        end_test("pixel readback with strobes", errors_before);

        // Two full frames from column 0 are checked by the deserializer
        errors_before = errors;
        expect_col = '0;
        set_scan(1'b1);
        wait_latches(latch_count + 2 * `LED_COLUMNS);
        end_test("column content", errors_before);

        errors_before = errors;
        wait_latches(latch_count + `LED_COLUMNS);
        set_scan(1'b0);
        drain_scan();
        axi_read(12'(`LED_REG_STATUS), data, resp);
        check("status frame count", 32'(frame_pulses & 255), 32'(data[7:0]));
        check("status busy", 32'd0, 32'(data[8]));
        end_test("scan order and frame pulse", errors_before);

        // New content is written while idle and the restart must begin at column 0
        errors_before = errors;
        for (int idx = 0; idx < `LED_RAM_DEPTH; idx++) begin
            data = next_rand();
            write_pixel(idx, data, 4'(next_rand()));
        end
        expect_col = '0;
        set_scan(1'b1);
        wait_latches(latch_count + `LED_COLUMNS);
        set_scan(1'b0);
        drain_scan();
        end_test("disable and restart", errors_before);

        // Anything above the status register is unmapped
        errors_before = errors;
        axi_read(12'(`LED_REG_STATUS), status_before, resp);
        bad_addr = 12'(`LED_REG_STATUS + 4 + 4 * (next_rand() % 894));
        axi_write(bad_addr, next_rand() | 32'd1, 4'hf, resp);
        check("unmapped write response", 32'(RESP_SLVERR), 32'(resp));
        axi_read(bad_addr, data, resp);
        check("unmapped read data", 32'd0, data);
        check("unmapped read response", 32'(RESP_SLVERR), 32'(resp));
        for (int idx = 0; idx < `LED_RAM_DEPTH; idx++) begin
            axi_read(12'(idx * 4), data, resp);
            check("pixel after unmapped write", {8'h00, model[idx]}, data);
        end
        axi_read(12'(`LED_REG_CTRL), data, resp);
        check("control after unmapped write", 32'd0, data);
        axi_read(12'(`LED_REG_STATUS), data, resp);
        check("status after unmapped write", status_before, data);
        end_test("bad address", errors_before);

        finish_run();
    end

endmodule

`default_nettype wire

// ==== design/led_panel_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_panel_defines.svh"

module led_panel_top (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic [`LED_AXI_ADDR_W-1:0]      awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [`LED_AXI_DATA_W-1:0]      wdata,
    input  logic [`LED_AXI_DATA_W/8-1:0]    wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output logic [1:0]                      bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [`LED_AXI_ADDR_W-1:0]      araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [`LED_AXI_DATA_W-1:0]      rdata,
    output logic [1:0]                      rresp,
    output logic                            rvalid,
    input  logic                            rready,
    output logic [`LED_DRIVERS-1:0]         sdo,
    output logic                            shift_en,
    output logic                            latch,
    output logic [$clog2(`LED_COLUMNS)-1:0] col_sel,
    output logic                            frame_done
);

    logic                     ram_we;
    led_panel_pkg::ram_addr_t ram_waddr;
    led_panel_pkg::pixel_t    ram_wdata;
    led_panel_pkg::ram_addr_t ram_raddr;
    led_panel_pkg::pixel_t    ram_rdata;
    led_panel_pkg::ram_addr_t scan_addr;
    led_panel_pkg::pixel_t    scan_data;
    logic                     scan_en;
    logic                     scan_busy;

    // Column handoff from buffer to shifter
    column_if col_link ();

    axil_pixel_writer i_writer (
        .clk, .nrst,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .ram_we, .ram_waddr, .ram_wdata, .ram_raddr, .ram_rdata,
        .scan_en, .latch, .col_sel, .busy (scan_busy)
    );

    pixel_ram i_ram (
        .clk,
        .we         (ram_we),
        .waddr      (ram_waddr),
        .wdata      (ram_wdata),
        .host_raddr (ram_raddr),
        .host_rdata (ram_rdata),
        .scan_raddr (scan_addr),
        .scan_rdata (scan_data)
    );

    column_buffer i_buffer (
        .clk, .nrst, .scan_en,
        .rd_addr (scan_addr),
        .rd_data (scan_data),
        .busy    (scan_busy),
        .col_out (col_link.producer)
    );

    driver_shifter i_shifter (
        .clk, .nrst,
        .col_in (col_link.consumer),
        .sdo, .shift_en, .latch, .col_sel, .frame_done
    );

endmodule

`default_nettype wire

// ==== design/driver_shifter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_panel_defines.svh"

module driver_shifter (
    input  logic                         clk,
    input  logic                         nrst,
    column_if.consumer                   col_in,
    output logic [`LED_DRIVERS-1:0]      sdo,
    output logic                         shift_en,
    output logic                         latch,
    output led_panel_pkg::col_idx_t      col_sel,
    output logic                         frame_done
);

    typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_LATCH} state_e;

    state_e                                state;
    led_panel_pkg::column_t                shift_reg;
    led_panel_pkg::col_idx_t               pend_col;
    logic [$clog2(`LED_CHANNELS)-1:0]      bit_cnt;

    // Only an idle shifter takes a new column
    assign col_in.ready = (state == ST_IDLE);

    assign shift_en = (state == ST_SHIFT);
    assign latch    = (state == ST_LATCH);

    // col_sel already shows the new column during the latch cycle
    assign frame_done = latch &&
        (col_sel == led_panel_pkg::col_idx_t'(`LED_COLUMNS - 1));

    // Lane d carries the top bit of driver d's word
    always_comb begin
        for (int d = 0; d < `LED_DRIVERS; d++) begin
            sdo[d] = shift_reg[d*`LED_CHANNELS + `LED_CHANNELS - 1];
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            col_sel <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (col_in.valid) begin
                        state   <= ST_SHIFT;
                        bit_cnt <= '0;
                    end
                end
                ST_SHIFT: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == `LED_CHANNELS - 1) begin
                        state   <= ST_LATCH;
                        col_sel <= pend_col;
                    end
                end
                // One latch cycle, then ready again
                ST_LATCH: state <= ST_IDLE;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // Shifting the whole column left moves each word's next bit to its top.
    // Bits spilling in from the word below only reach the top after 24 shifts
    always_ff @(posedge clk) begin
        if (col_in.valid && col_in.ready) begin
            shift_reg <= col_in.data;
            pend_col  <= col_in.col;
        end else if (shift_en) begin
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

`default_nettype wire

// ==== design/column_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_panel_defines.svh"

module column_buffer (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     scan_en,
    output led_panel_pkg::ram_addr_t rd_addr,
    input  led_panel_pkg::pixel_t    rd_data,
    output logic                     busy,
    column_if.producer               col_out
);

    localparam int COL_W = `LED_DRIVERS * `LED_CHANNELS;
    localparam int DRV_W = $clog2(`LED_DRIVERS);
    // One extra count for the memory latency after the last address
    localparam int CNT_W = DRV_W + 1;

    typedef enum logic [1:0] {ST_IDLE, ST_FILL, ST_HOLD} state_e;

    state_e                  state;
    logic [CNT_W-1:0]        fill_cnt;
    logic                    fill_half;
    led_panel_pkg::col_idx_t fill_col;
    led_panel_pkg::column_t  halves [2];
    logic                    take;

    assign take = col_out.valid && col_out.ready;

    // With 8 columns, c + 8 * d is just the driver index above the column bits
    assign rd_addr = {fill_cnt[DRV_W-1:0], fill_col};

    // The half just filled is offered until the shifter takes it
    assign col_out.data  = halves[fill_half];
    assign col_out.col   = fill_col;
    assign col_out.valid = (state == ST_HOLD);

    // Busy covers every column still in progress after enable falls
    assign busy = (state != ST_IDLE);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= ST_IDLE;
            fill_cnt  <= '0;
            fill_half <= 1'b0;
            fill_col  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // A fresh enable always restarts the scan at column 0
                    if (scan_en) begin
                        state    <= ST_FILL;
                        fill_cnt <= '0;
                        fill_col <= '0;
                    end
                end
                ST_FILL: begin
                    // 16 addresses go out, the 17th cycle catches the last word
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_cnt == CNT_W'(`LED_DRIVERS)) state <= ST_HOLD;
                end
                ST_HOLD: begin
                    if (take) begin
                        // Swap halves so the taken column stays intact while
                        // the next one is gathered
                        fill_half <= ~fill_half;
                        fill_col  <= fill_col + 1'b1;
                        fill_cnt  <= '0;
                        state     <= scan_en ? ST_FILL : ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Each returned pixel enters at the top, so driver 0 ends in the low word
    always_ff @(posedge clk) begin
        if (state == ST_FILL && fill_cnt != '0) begin
            halves[fill_half] <= {rd_data, halves[fill_half][COL_W-1:`LED_CHANNELS]};
        end
    end

endmodule

`default_nettype wire

// ==== design/pixel_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_panel_defines.svh"

module pixel_ram (
    input  logic                     clk,
    input  logic                     we,
    input  led_panel_pkg::ram_addr_t waddr,
    input  led_panel_pkg::pixel_t    wdata,
    input  led_panel_pkg::ram_addr_t host_raddr,
    output led_panel_pkg::pixel_t    host_rdata,
    input  led_panel_pkg::ram_addr_t scan_raddr,
    output led_panel_pkg::pixel_t    scan_rdata
);

    // Pixel d of column c sits at address c + 8 * d
    led_panel_pkg::pixel_t mem [`LED_RAM_DEPTH];

    // Host write port
    always_ff @(posedge clk) begin
        if (we) mem[waddr] <= wdata;
    end

    // Both read ports return the old word when the same address is written
    always_ff @(posedge clk) begin
        host_rdata <= mem[host_raddr];
    end

    // Scan read port, owned by the column buffer
    always_ff @(posedge clk) begin
        scan_rdata <= mem[scan_raddr];
    end

endmodule

`default_nettype wire

// ==== design/axil_pixel_writer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "led_panel_defines.svh"

module axil_pixel_writer (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic [`LED_AXI_ADDR_W-1:0]      awaddr,
    input  logic                            awvalid,
    output logic                            awready,
    input  logic [`LED_AXI_DATA_W-1:0]      wdata,
    input  logic [`LED_AXI_DATA_W/8-1:0]    wstrb,
    input  logic                            wvalid,
    output logic                            wready,
    output led_panel_pkg::axi_resp_t        bresp,
    output logic                            bvalid,
    input  logic                            bready,
    input  logic [`LED_AXI_ADDR_W-1:0]      araddr,
    input  logic                            arvalid,
    output logic                            arready,
    output logic [`LED_AXI_DATA_W-1:0]      rdata,
    output led_panel_pkg::axi_resp_t        rresp,
    output logic                            rvalid,
    input  logic                            rready,
    output logic                            ram_we,
    output led_panel_pkg::ram_addr_t        ram_waddr,
    output led_panel_pkg::pixel_t           ram_wdata,
    output led_panel_pkg::ram_addr_t        ram_raddr,
    input  led_panel_pkg::pixel_t           ram_rdata,
    output logic                            scan_en,
    input  logic                            latch,
    input  led_panel_pkg::col_idx_t         col_sel,
    input  logic                            busy
);

    typedef enum logic [1:0] {SEL_PIXEL, SEL_CTRL, SEL_STATUS, SEL_NONE} reg_sel_e;

    logic                       wr_go;
    logic                       rd_go;
    logic                       wr_pend;
    led_panel_pkg::ram_addr_t   wr_idx;
    led_panel_pkg::pixel_t      wr_pixel;
    logic [`LED_CHANNELS/8-1:0] wr_bytes;
    logic                       rd_pend;
    reg_sel_e                   rd_sel;
    logic [7:0]                 frame_cnt;

    // Everything below the control register is pixel memory, word aligned
    function automatic reg_sel_e decode(input logic [`LED_AXI_ADDR_W-1:0] addr);
        logic [`LED_AXI_ADDR_W-1:0] word;
        word = {addr[`LED_AXI_ADDR_W-1:2], 2'b00};
        if (word < `LED_REG_CTRL) return SEL_PIXEL;
        if (word == `LED_REG_CTRL) return SEL_CTRL;
        if (word == `LED_REG_STATUS) return SEL_STATUS;
        return SEL_NONE;
    endfunction

    // A write needs address and data together, and only one response in flight
    assign wr_go   = awvalid && wvalid && !bvalid;
    assign awready = wr_go;
    assign wready  = wr_go;
    // Writes win the shared host read port, reads wait one cycle
    assign rd_go   = arvalid && !rd_pend && !rvalid && !wr_go;
    assign arready = rd_go;

    // A pixel write first reads the old word so unstrobed bytes survive
    assign ram_raddr = wr_go ? led_panel_pkg::ram_addr_t'(awaddr >> 2)
                             : led_panel_pkg::ram_addr_t'(araddr >> 2);
    assign ram_we    = wr_pend;
    assign ram_waddr = wr_idx;

    always_comb begin
        ram_wdata = ram_rdata;
        for (int b = 0; b < `LED_CHANNELS/8; b++) begin
            if (wr_bytes[b]) ram_wdata[b*8 +: 8] = wr_pixel[b*8 +: 8];
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            bvalid  <= 1'b0;
            wr_pend <= 1'b0;
            scan_en <= 1'b0;
        end else begin
            wr_pend <= 1'b0;
            if (bvalid && bready) bvalid <= 1'b0;
            if (wr_go) begin
                bvalid <= 1'b1;
                // Status is read only and unmapped writes are dropped
                if (decode(awaddr) == SEL_PIXEL) wr_pend <= 1'b1;
                if (decode(awaddr) == SEL_CTRL && wstrb[0]) scan_en <= wdata[0];
            end
        end
    end

    // Write payload, merged with the old word one cycle after the transfer
    always_ff @(posedge clk) begin
        if (wr_go) begin
            wr_idx   <= led_panel_pkg::ram_addr_t'(awaddr >> 2);
            wr_pixel <= wdata[`LED_CHANNELS-1:0];
            wr_bytes <= wstrb[`LED_CHANNELS/8-1:0];
            bresp    <= (decode(awaddr) == SEL_NONE) ? led_panel_pkg::SLVERR
                                                      : led_panel_pkg::OKAY;
        end
    end

    // Read pipeline, address in the first cycle and data captured in the second
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd_pend <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            rd_pend <= rd_go;
            if (rvalid && rready) rvalid <= 1'b0;
            if (rd_pend) rvalid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) rd_sel <= decode(araddr);
        if (rd_pend) begin
            rdata <= '0;
            rresp <= led_panel_pkg::OKAY;
            case (rd_sel)
                SEL_PIXEL:  rdata[`LED_CHANNELS-1:0] <= ram_rdata;
                SEL_CTRL:   rdata[0] <= scan_en;
                SEL_STATUS: begin
                    rdata[7:0] <= frame_cnt;
                    rdata[8]   <= busy;
                end
                default:    rresp <= led_panel_pkg::SLVERR;
            endcase
        end
    end

    // One frame ends with the latch of the last column
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            frame_cnt <= '0;
        end else if (latch && col_sel == led_panel_pkg::col_idx_t'(`LED_COLUMNS - 1)) begin
            frame_cnt <= frame_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== design/column_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Carries one complete column from the buffer to the driver shifter
interface column_if;

    led_panel_pkg::column_t  data;
    led_panel_pkg::col_idx_t col;
    logic                    valid;
    logic                    ready;

    // The buffer holds data and col stable while valid waits for ready
    modport producer (output data, output col, output valid, input ready);

    modport consumer (input data, input col, input valid, output ready);

endinterface

`default_nettype wire

// ==== design/led_panel_pkg.sv ====
`default_nettype none

`include "led_panel_defines.svh"

package led_panel_pkg;

    // One RGB pixel as stored in memory and shifted to a driver
    typedef logic [`LED_CHANNELS-1:0] pixel_t;

    // Word address into the pixel memory
    typedef logic [$clog2(`LED_RAM_DEPTH)-1:0] ram_addr_t;

    // Index of the scan column being filled or shown
    typedef logic [$clog2(`LED_COLUMNS)-1:0] col_idx_t;

    // One pixel per driver for a single column, driver 0 in the low word
    typedef logic [`LED_DRIVERS*`LED_CHANNELS-1:0] column_t;

    // AXI response codes used by the host port
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

`default_nettype wire

// ==== design/led_panel_defines.svh ====
`ifndef LED_PANEL_DEFINES_SVH
`define LED_PANEL_DEFINES_SVH

// Panel geometry, 16 driver chips each driving 8 RGB pixels of one column group
`define LED_DRIVERS 16
// Channels per driver chip, which is also the width of one RGB pixel word
`define LED_CHANNELS 24
// Number of multiplexed scan columns
`define LED_COLUMNS 8
// One pixel word per driver and column
`define LED_RAM_DEPTH (`LED_DRIVERS * `LED_COLUMNS)

// Host bus widths
`define LED_AXI_ADDR_W 12
`define LED_AXI_DATA_W 32

// Control register, bit 0 enables scanning
`define LED_REG_CTRL 'h200
// Status register, frame count in bits 7:0 and busy in bit 8
`define LED_REG_STATUS 'h204

`endif
